// ==== flist.f ====
hdl/fetch_pkg.sv
hdl/fetch_fifo.sv
hdl/fetch_btb.sv
hdl/riscv_ifu.sv
hdl/fetch_top.sv
test/tb_wb_inst_mem.sv
test/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_fetch_top
FLIST     = flist.f
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# The run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== test/tb_fetch_top.sv ====
`default_nettype none

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int unsigned     FIFO_DEPTH  = 8;
  localparam int unsigned     BTB_ENTRIES = 16;
  localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_1000;
  localparam int              TIMEOUT     = 2000;
  localparam int              NUM_ROWS    = 7;

  typedef struct packed {
    logic            stall;
    logic [7:0]      n_inst;
    logic [7:0]      freeze;
    logic            miss;
    logic [XLEN-1:0] miss_pc;
    logic            upd;
    logic [XLEN-1:0] upd_pc;
    logic [XLEN-1:0] upd_target;
  } row_t;

  logic             clk;
  logic             rst;
  logic             exu_vld;
  logic             exu_freeze;
  logic             exu_br_miss;
  logic [XLEN-1:0]  exu_pc_next;
  logic             exu_br_resolve;
  logic [XLEN-1:0]  exu_br_pc;
  logic [XLEN-1:0]  exu_br_target;
  logic             stall_en;
  logic [XLEN-1:0]  bus_adr;
  logic             bus_stb;
  logic             bus_cyc;
  logic             bus_tga;
  logic [ERA_W-1:0] bus_tgc_req;
  logic             bus_ack;
  logic             bus_stall;
  logic [XLEN-1:0]  bus_data;
  logic [ERA_W-1:0] bus_tgc_rsp;
  logic             ifu_vld;
  logic [XLEN-1:0]  ifu_inst;
  logic [XLEN-1:0]  ifu_pc;
  logic             ifu_taken;
  logic [XLEN-1:0]  ifu_pred_next;

  row_t             rows [NUM_ROWS];
  logic [XLEN-1:0]  btb_model [logic [XLEN-1:0]];
  logic [XLEN-1:0]  exp_pc         = RESET_PC;
  int               issued_cnt     = 0;
  int               check_cnt      = 0;
  int               value_errors   = 0;
  int               timeout_errors = 0;
  bit               timed_out      = 1'b0;
  bit               was_frozen     = 1'b0;
  logic             prev_vld;
  logic [XLEN-1:0]  prev_inst;
  logic [XLEN-1:0]  prev_pc;
  logic             prev_taken;
  logic [XLEN-1:0]  prev_next;

  fetch_top #(
    .FIFO_DEPTH  ( FIFO_DEPTH  ),
    .BTB_ENTRIES ( BTB_ENTRIES ),
    .RESET_PC    ( RESET_PC    )
  ) fetch_top_i (
    .clk                        ( clk            ),
    .rst                        ( rst            ),
    .exu_vld_i                  ( exu_vld        ),
    .exu_freeze_i               ( exu_freeze     ),
    .exu_br_miss_i              ( exu_br_miss    ),
    .exu_pc_next_i              ( exu_pc_next    ),
    .exu_br_resolve_i           ( exu_br_resolve ),
    .exu_br_pc_i                ( exu_br_pc      ),
    .exu_br_target_i            ( exu_br_target  ),
    .bus_inst_adr_o             ( bus_adr        ),
    .bus_inst_stb_o             ( bus_stb        ),
    .bus_inst_cyc_o             ( bus_cyc        ),
    .bus_inst_tga_o             ( bus_tga        ),
    .bus_inst_tgc_o             ( bus_tgc_req    ),
    .bus_inst_ack_i             ( bus_ack        ),
    .bus_inst_stall_i           ( bus_stall      ),
    .bus_inst_data_i            ( bus_data       ),
    .bus_inst_tgc_i             ( bus_tgc_rsp    ),
    .ifu_vld_o                  ( ifu_vld        ),
    .ifu_inst_o                 ( ifu_inst       ),
    .ifu_inst_pc_o              ( ifu_pc         ),
    .ifu_inst_br_taken_o        ( ifu_taken      ),
    .ifu_inst_br_pred_pc_next_o ( ifu_pred_next  )
  );

  tb_wb_inst_mem mem_i (
    .clk        ( clk         ),
    .stall_en_i ( stall_en    ),
    .cyc_i      ( bus_cyc     ),
    .stb_i      ( bus_stb     ),
    .adr_i      ( bus_adr     ),
    .tgc_i      ( bus_tgc_req ),
    .stall_o    ( bus_stall   ),
    .ack_o      ( bus_ack     ),
    .data_o     ( bus_data    ),
    .tgc_o      ( bus_tgc_rsp )
  );

  initial
    begin
    clk = 1'b0;
    forever #4 clk = ~clk;
    end

  // Same scramble the memory applies to every fetch address
  function automatic logic [XLEN-1:0] inst_word(input logic [XLEN-1:0] adr);
    return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    check_cnt++;
    assert (got === exp)
    else
      begin
      value_errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
  endtask

  // Next PC is the trained target on a BTB hit, else the next word
  task automatic check_issue();
    logic            hit;
    logic [XLEN-1:0] exp_next;
    hit      = (btb_model.exists(exp_pc) != 0);
    exp_next = hit ? btb_model[exp_pc] : exp_pc + XLEN'(INST_BYTES);
    check_value("ifu_inst_pc_o", ifu_pc, exp_pc);
    check_value("ifu_inst_o", ifu_inst, inst_word(exp_pc));
    check_value("ifu_inst_br_taken_o", XLEN'(ifu_taken), XLEN'(hit));
    check_value("ifu_inst_br_pred_pc_next_o", ifu_pred_next, exp_next);
    exp_pc = exp_next;
    issued_cnt++;
  endtask

  task automatic check_hold();
    check_value("ifu_vld_o", XLEN'(ifu_vld), XLEN'(prev_vld));
    check_value("ifu_inst_o", ifu_inst, prev_inst);
    check_value("ifu_inst_pc_o", ifu_pc, prev_pc);
    check_value("ifu_inst_br_taken_o", XLEN'(ifu_taken), XLEN'(prev_taken));
    check_value("ifu_inst_br_pred_pc_next_o", ifu_pred_next, prev_next);
  endtask

  // Decode takes an instruction on every unfrozen cycle with ifu_vld_o high
  always @(negedge clk)
    begin
    if (rst)
      begin
      check_value("ifu_vld_o", XLEN'(ifu_vld), '0);
      check_value("bus_inst_stb_o", XLEN'(bus_stb), '0);
      check_value("bus_inst_cyc_o", XLEN'(bus_cyc), '0);
      end
    else
      begin
      // A request carries the BTB prediction from before this cycle's update
      if (bus_stb)
        check_value("bus_inst_tga_o", XLEN'(bus_tga),
                    XLEN'(btb_model.exists(bus_adr) != 0));
      if (was_frozen)
        check_hold();
      if (exu_vld && exu_br_miss)
        begin
        // The instruction in the issue register is squashed
        exp_pc = exu_pc_next;
        if (exu_br_resolve)
          btb_model[exu_br_pc] = exu_br_target;
        end
      else if (ifu_vld && !(exu_vld && exu_freeze))
        check_issue();
      end
    was_frozen = !rst && exu_vld && exu_freeze;
    prev_vld   = ifu_vld;
    prev_inst  = ifu_inst;
    prev_pc    = ifu_pc;
    prev_taken = ifu_taken;
    prev_next  = ifu_pred_next;
    end

  task automatic report_timeout(input string what);
    timeout_errors++;
    timed_out = 1'b1;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic wait_issued(input int target);
    int cycles;
    cycles = 0;
    while (issued_cnt < target && cycles < TIMEOUT)
      begin
      @(posedge clk);
      cycles++;
      end
    if (issued_cnt < target)
      report_timeout($sformatf("only %0d of %0d instructions issued", issued_cnt, target));
  endtask

  task automatic send_miss(input row_t r);
    exu_vld        = 1'b1;
    exu_br_miss    = 1'b1;
    exu_pc_next    = r.miss_pc;
    exu_br_resolve = r.upd;
    exu_br_pc      = r.upd_pc;
    exu_br_target  = r.upd_target;
    @(posedge clk);
    #1;
    exu_vld        = 1'b0;
    exu_br_miss    = 1'b0;
    exu_br_resolve = 1'b0;
  endtask

  task automatic hold_freeze(input int n);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ifu_vld && cycles < TIMEOUT)
      begin
      @(negedge clk);
      cycles++;
      end
    if (!ifu_vld)
      report_timeout("no valid instruction reached decode before the freeze");
    else
      begin
      @(posedge clk);
      #1;
      exu_vld    = 1'b1;
      exu_freeze = 1'b1;
      repeat (n) @(posedge clk);
      #1;
      exu_vld    = 1'b0;
      exu_freeze = 1'b0;
      end
  endtask

  task automatic apply_row(input row_t r);
    int target;
    @(posedge clk);
    #1;
    stall_en = r.stall;
    if (r.miss)
      send_miss(r);
    if (r.freeze != '0)
      hold_freeze(int'(r.freeze));
    target = issued_cnt + int'(r.n_inst);
    if (!timed_out)
      wait_issued(target);
  endtask

  // stall, count, freeze, miss, miss target, update, update pc, update target
  task automatic load_table();
    rows[0] = '{1'b0, 8'd12, 8'd0, 1'b0, 32'h0, 1'b0, 32'h0, 32'h0};
    rows[1] = '{1'b1, 8'd40, 8'd0, 1'b0, 32'h0, 1'b0, 32'h0, 32'h0};
    rows[2] = '{1'b0, 8'd10, 8'd6, 1'b0, 32'h0, 1'b0, 32'h0, 32'h0};
    rows[3] = '{1'b1, 8'd20, 8'd0, 1'b1, 32'h0000_2000, 1'b0, 32'h0, 32'h0};
    rows[4] = '{1'b0, 8'd16, 8'd0, 1'b1, 32'h0000_30F0, 1'b1, 32'h0000_3100, 32'h0000_3400};
    // Second entry closes a loop back through the first one
    rows[5] = '{1'b1, 8'd30, 8'd0, 1'b1, 32'h0000_3400, 1'b1, 32'h0000_3410, 32'h0000_3100};
    rows[6] = '{1'b1, 8'd20, 8'd4, 1'b0, 32'h0, 1'b0, 32'h0, 32'h0};
  endtask

  initial
    begin
    rst            = 1'b1;
    exu_vld        = 1'b0;
    exu_freeze     = 1'b0;
    exu_br_miss    = 1'b0;
    exu_pc_next    = '0;
    exu_br_resolve = 1'b0;
    exu_br_pc      = '0;
    exu_br_target  = '0;
    stall_en       = 1'b0;
    load_table();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++)
      begin
      if (!timed_out)
        apply_row(rows[i]);
      end
    @(posedge clk);
    $display("Checks: %0d, issued: %0d, value errors: %0d, timeouts: %0d",
             check_cnt, issued_cnt, value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_wb_inst_mem.sv ====
`default_nettype none

module tb_wb_inst_mem (
  input  logic                        clk,
  input  logic                        stall_en_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic [fetch_pkg::XLEN-1:0]  adr_i,
  input  logic [fetch_pkg::ERA_W-1:0] tgc_i,
  output logic                        stall_o,
  output logic                        ack_o,
  output logic [fetch_pkg::XLEN-1:0]  data_o,
  output logic [fetch_pkg::ERA_W-1:0] tgc_o
);
  import fetch_pkg::*;

  int               seed;
  logic             stall_en;
  logic             req_vld;
  logic [XLEN-1:0]  req_adr;
  logic [ERA_W-1:0] req_tgc;
  logic             pend_vld;
  logic [XLEN-1:0]  pend_adr;
  logic [ERA_W-1:0] pend_tgc;

  // Every address bit reaches the returned word
  function automatic logic [XLEN-1:0] inst_word(input logic [XLEN-1:0] adr);
    return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  initial
    begin
    seed     = 12;
    stall_o  = 1'b0;
    ack_o    = 1'b0;
    data_o   = '0;
    tgc_o    = '0;
    stall_en = 1'b0;
    req_vld  = 1'b0;
    req_adr  = '0;
    req_tgc  = '0;
    pend_vld = 1'b0;
    pend_adr = '0;
    pend_tgc = '0;
    end

  // Bus inputs are settled by the falling edge
  always @(negedge clk)
    begin
    req_vld  = (cyc_i === 1'b1) && (stb_i === 1'b1) && (stall_o !== 1'b1);
    req_adr  = adr_i;
    req_tgc  = tgc_i;
    stall_en = (stall_en_i === 1'b1);
    end

  // Ack comes two cycles after the request cycle, tag echoed
  always @(posedge clk)
    begin
    #1;
    ack_o    = pend_vld;
    data_o   = pend_vld ? inst_word(pend_adr) : '0;
    tgc_o    = pend_tgc;
    pend_vld = req_vld;
    pend_adr = req_adr;
    pend_tgc = req_tgc;
    stall_o  = stall_en && ($random(seed) % 4 == 0);
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`default_nettype none

module fetch_top #(
  parameter int unsigned                FIFO_DEPTH  = 8,
  parameter int unsigned                BTB_ENTRIES = 16,
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = '0
) (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        exu_vld_i,
  input  logic                        exu_freeze_i,
  input  logic                        exu_br_miss_i,
  input  logic [fetch_pkg::XLEN-1:0]  exu_pc_next_i,
  input  logic                        exu_br_resolve_i,
  input  logic [fetch_pkg::XLEN-1:0]  exu_br_pc_i,
  input  logic [fetch_pkg::XLEN-1:0]  exu_br_target_i,

  output logic [fetch_pkg::XLEN-1:0]  bus_inst_adr_o,
  output logic                        bus_inst_stb_o,
  output logic                        bus_inst_cyc_o,
  output logic                        bus_inst_tga_o,
  output logic [fetch_pkg::ERA_W-1:0] bus_inst_tgc_o,
  input  logic                        bus_inst_ack_i,
  input  logic                        bus_inst_stall_i,
  input  logic [fetch_pkg::XLEN-1:0]  bus_inst_data_i,
  input  logic [fetch_pkg::ERA_W-1:0] bus_inst_tgc_i,

  output logic                        ifu_vld_o,
  output logic [fetch_pkg::XLEN-1:0]  ifu_inst_o,
  output logic [fetch_pkg::XLEN-1:0]  ifu_inst_pc_o,
  output logic                        ifu_inst_br_taken_o,
  output logic [fetch_pkg::XLEN-1:0]  ifu_inst_br_pred_pc_next_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] fetch_pc;
  logic            pred_taken;
  logic [XLEN-1:0] pred_target;
  logic            btb_upd;

  // Branch resolution from execute trains the BTB
  assign btb_upd = exu_vld_i & exu_br_resolve_i;

  riscv_ifu #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .RESET_PC   ( RESET_PC   )
  ) riscv_ifu_i (
    .clk                        ( clk                        ),
    .rst                        ( rst                        ),
    .exu_vld_i                  ( exu_vld_i                  ),
    .exu_freeze_i               ( exu_freeze_i               ),
    .exu_br_miss_i              ( exu_br_miss_i              ),
    .exu_pc_next_i              ( exu_pc_next_i              ),
    .fetch_pc_o                 ( fetch_pc                   ),
    .pred_taken_i               ( pred_taken                 ),
    .pred_target_i              ( pred_target                ),
    .bus_inst_adr_o             ( bus_inst_adr_o             ),
    .bus_inst_data_o            (                            ),
    .bus_inst_we_o              (                            ),
    .bus_inst_sel_o             (                            ),
    .bus_inst_stb_o             ( bus_inst_stb_o             ),
    .bus_inst_cyc_o             ( bus_inst_cyc_o             ),
    .bus_inst_tga_o             ( bus_inst_tga_o             ),
    .bus_inst_tgc_o             ( bus_inst_tgc_o             ),
    .bus_inst_ack_i             ( bus_inst_ack_i             ),
    .bus_inst_stall_i           ( bus_inst_stall_i           ),
    .bus_inst_data_i            ( bus_inst_data_i            ),
    .bus_inst_tgc_i             ( bus_inst_tgc_i             ),
    .ifu_vld_o                  ( ifu_vld_o                  ),
    .ifu_inst_o                 ( ifu_inst_o                 ),
    .ifu_inst_pc_o              ( ifu_inst_pc_o              ),
    .ifu_inst_br_taken_o        ( ifu_inst_br_taken_o        ),
    .ifu_inst_br_pred_pc_next_o ( ifu_inst_br_pred_pc_next_o )
  );

  fetch_btb #(
    .ENTRIES ( BTB_ENTRIES )
  ) fetch_btb_i (
    .clk           ( clk             ),
    .rst           ( rst             ),
    .fetch_pc_i    ( fetch_pc        ),
    .pred_taken_o  ( pred_taken      ),
    .pred_target_o ( pred_target     ),
    .upd_i         ( btb_upd         ),
    .upd_pc_i      ( exu_br_pc_i     ),
    .upd_target_i  ( exu_br_target_i )
  );

endmodule

`default_nettype wire

// ==== hdl/riscv_ifu.sv ====
`default_nettype none

module riscv_ifu #(
  parameter int unsigned                FIFO_DEPTH = 8,
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC   = '0
) (
  input  logic                            clk,
  input  logic                            rst,

  input  logic                            exu_vld_i,
  input  logic                            exu_freeze_i,
  input  logic                            exu_br_miss_i,
  input  logic [fetch_pkg::XLEN-1:0]      exu_pc_next_i,

  output logic [fetch_pkg::XLEN-1:0]      fetch_pc_o,
  input  logic                            pred_taken_i,
  input  logic [fetch_pkg::XLEN-1:0]      pred_target_i,

  output logic [fetch_pkg::XLEN-1:0]      bus_inst_adr_o,
  output logic [fetch_pkg::XLEN-1:0]      bus_inst_data_o,
  output logic                            bus_inst_we_o,
  output logic [fetch_pkg::BUS_SEL_W-1:0] bus_inst_sel_o,
  output logic                            bus_inst_stb_o,
  output logic                            bus_inst_cyc_o,
  output logic                            bus_inst_tga_o,
  output logic [fetch_pkg::ERA_W-1:0]     bus_inst_tgc_o,

  input  logic                            bus_inst_ack_i,
  input  logic                            bus_inst_stall_i,
  input  logic [fetch_pkg::XLEN-1:0]      bus_inst_data_i,
  input  logic [fetch_pkg::ERA_W-1:0]     bus_inst_tgc_i,

  output logic                            ifu_vld_o,
  output logic [fetch_pkg::XLEN-1:0]      ifu_inst_o,
  output logic [fetch_pkg::XLEN-1:0]      ifu_inst_pc_o,
  output logic                            ifu_inst_br_taken_o,
  output logic [fetch_pkg::XLEN-1:0]      ifu_inst_br_pred_pc_next_o
);
  import fetch_pkg::*;

  // Address queue entry holds PC, taken flag and predicted next PC
  localparam int unsigned AQ_W = 2 * XLEN + 1;

  logic                  frozen;
  logic                  br_miss;
  logic                  req_accept;
  logic                  ack_match;

  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       pc_seq;
  logic [XLEN-1:0]       pc_pred_next;
  logic [ERA_W-1:0]      era;
  logic                  clear_q;

  logic                  addr_wr_q;
  logic [AQ_W-1:0]       addr_wdata_q;
  logic [AQ_W-1:0]       addr_rdata;
  logic                  addr_empty;
  logic                  addr_almost_full;

  logic                  data_wr_q;
  logic [XLEN-1:0]       data_wdata_q;
  logic [XLEN-1:0]       data_rdata;
  logic                  data_empty;
  logic [FIFO_CNT_W-1:0] data_count;

  logic                  issue_avail;
  logic                  pop;

  assign frozen  = exu_vld_i & exu_freeze_i;
  assign br_miss = exu_vld_i & exu_br_miss_i;

  assign pc_seq       = pc + XLEN'(INST_BYTES);
  assign pc_pred_next = pred_taken_i ? pred_target_i : pc_seq;

  // Keep issuing while the queue has room for the in-flight responses
  assign bus_inst_stb_o  = ~rst & ~addr_almost_full & ~bus_inst_stall_i;
  assign bus_inst_cyc_o  = bus_inst_stb_o;
  assign bus_inst_adr_o  = pc;
  assign bus_inst_tga_o  = pred_taken_i;
  assign bus_inst_tgc_o  = era;
  assign bus_inst_we_o   = 1'b0;
  assign bus_inst_sel_o  = '1;
  assign bus_inst_data_o = '0;

  assign fetch_pc_o = pc;
  assign req_accept = bus_inst_stb_o & ~bus_inst_stall_i;

  // Responses tagged with an older era belong to a flushed path
  assign ack_match = bus_inst_ack_i & (bus_inst_tgc_i == era);

  assign issue_avail = ~addr_empty & ~data_empty & ~clear_q;
  assign pop         = issue_avail & ~frozen & ~br_miss;

  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      pc        <= RESET_PC;
      era       <= '0;
      clear_q   <= 1'b0;
      addr_wr_q <= 1'b0;
      data_wr_q <= 1'b0;
      end
    else
      begin
      clear_q   <= br_miss;
      addr_wr_q <= req_accept;
      data_wr_q <= ack_match;
      if (br_miss)
        begin
        pc  <= exu_pc_next_i;
        era <= era + 1'b1;
        end
      else if (req_accept)
        begin
        pc <= pc_pred_next;
        end
      end
    end

  always_ff @(posedge clk)
    begin
    addr_wdata_q <= {pc, pred_taken_i, pc_pred_next};
    data_wdata_q <= bus_inst_data_i;
    end

  fetch_fifo #(
    .WIDTH ( AQ_W       ),
    .DEPTH ( FIFO_DEPTH )
  ) addr_fifo_i (
    .clk           ( clk              ),
    .rst           ( rst              ),
    .clear_i       ( clear_q          ),
    .wr_i          ( addr_wr_q        ),
    .wr_data_i     ( addr_wdata_q     ),
    .rd_i          ( pop              ),
    .rd_data_o     ( addr_rdata       ),
    .empty_o       ( addr_empty       ),
    .almost_full_o ( addr_almost_full ),
    .count_o       (                  )
  );

  fetch_fifo #(
    .WIDTH ( XLEN       ),
    .DEPTH ( FIFO_DEPTH )
  ) data_fifo_i (
    .clk           ( clk          ),
    .rst           ( rst          ),
    .clear_i       ( clear_q      ),
    .wr_i          ( data_wr_q    ),
    .wr_data_i     ( data_wdata_q ),
    .rd_i          ( pop          ),
    .rd_data_o     ( data_rdata   ),
    .empty_o       ( data_empty   ),
    .almost_full_o (              ),
    .count_o       ( data_count   )
  );

  // Issue register, held as a whole under freeze
  always_ff @(posedge clk)
    begin
    if (rst)
      ifu_vld_o <= 1'b0;
    else if (br_miss)
      ifu_vld_o <= 1'b0;
    else if (!frozen)
      ifu_vld_o <= issue_avail;
    end

  always_ff @(posedge clk)
    begin
    if (pop)
      begin
      ifu_inst_o                 <= data_rdata;
      ifu_inst_pc_o              <= addr_rdata[AQ_W-1 -: XLEN];
      ifu_inst_br_taken_o        <= addr_rdata[XLEN];
      ifu_inst_br_pred_pc_next_o <= addr_rdata[XLEN-1:0];
      end
    end

  // Address queue margin must also cover the data queue
  a_data_room: assert property (@(posedge clk) disable iff (rst)
    ack_match |=> (data_count != FIFO_CNT_W'(FIFO_DEPTH)) || clear_q);

endmodule

`default_nettype wire

// ==== hdl/fetch_btb.sv ====
`default_nettype none

module fetch_btb #(
  parameter int unsigned ENTRIES = 16
) (
  input  logic                       clk,
  input  logic                       rst,

  input  logic [fetch_pkg::XLEN-1:0] fetch_pc_i,
  output logic                       pred_taken_o,
  output logic [fetch_pkg::XLEN-1:0] pred_target_o,

  input  logic                       upd_i,
  input  logic [fetch_pkg::XLEN-1:0] upd_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] upd_target_i
);
  import fetch_pkg::*;

  localparam int unsigned IDX_W = $clog2(ENTRIES);
  localparam int unsigned TAG_W = XLEN - IDX_W - 2;

  logic              entry_vld    [ENTRIES];
  logic [TAG_W-1:0]  entry_tag    [ENTRIES];
  logic [XLEN-1:0]   entry_target [ENTRIES];

  logic [IDX_W-1:0]  look_idx;
  logic [TAG_W-1:0]  look_tag;
  logic [IDX_W-1:0]  upd_idx;
  logic [TAG_W-1:0]  upd_tag;

  // Word index above the two byte-offset bits
  assign look_idx = fetch_pc_i[IDX_W+1:2];
  assign look_tag = fetch_pc_i[XLEN-1:IDX_W+2];
  assign upd_idx  = upd_pc_i[IDX_W+1:2];
  assign upd_tag  = upd_pc_i[XLEN-1:IDX_W+2];

  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      for (int i = 0; i < ENTRIES; i++)
        entry_vld[i] <= 1'b0;
      end
    else if (upd_i)
      begin
      entry_vld[upd_idx] <= 1'b1;
      end
    end

  always_ff @(posedge clk)
    begin
    if (upd_i)
      begin
      entry_tag[upd_idx]    <= upd_tag;
      entry_target[upd_idx] <= upd_target_i;
      end
    end

  // Taken only on a valid hit
  always_comb
    begin
    pred_taken_o  = entry_vld[look_idx] && (entry_tag[look_idx] == look_tag);
    pred_target_o = entry_target[look_idx];
    end

  // Execute only resolves aligned branch addresses
  a_upd_aligned: assert property (@(posedge clk) disable iff (rst)
    upd_i |-> upd_pc_i[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/fetch_fifo.sv ====
`default_nettype none

module fetch_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              clear_i,
  input  logic                              wr_i,
  input  logic [WIDTH-1:0]                  wr_data_i,
  input  logic                              rd_i,
  output logic [WIDTH-1:0]                  rd_data_o,
  output logic                              empty_o,
  output logic                              almost_full_o,
  output logic [fetch_pkg::FIFO_CNT_W-1:0]  count_o
);
  import fetch_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [FIFO_CNT_W-1:0] count;

  // Pointer step with wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk)
    begin
    if (wr_i)
      mem[wr_ptr] <= wr_data_i;
    end

  always_ff @(posedge clk)
    begin
    if (rst || clear_i)
      begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      end
    else
      begin
      if (wr_i)
        wr_ptr <= ptr_inc(wr_ptr);
      if (rd_i)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_i, rd_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      end
    end

  // Show-ahead head of queue
  assign rd_data_o     = mem[rd_ptr];
  assign empty_o       = (count == '0);
  assign almost_full_o = (count >= FIFO_CNT_W'(DEPTH - 2));
  assign count_o       = count;

  // Writers must respect the almost-full margin
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    wr_i && !rd_i && !clear_i |-> count != FIFO_CNT_W'(DEPTH));

  // Readers only pop a queue that holds data
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    rd_i && !clear_i |-> count != '0);

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // Address and instruction word width
  localparam int unsigned XLEN = 32;

  // Byte lanes of the instruction bus
  localparam int unsigned BUS_SEL_W = XLEN / 8;

  // Branch era tag carried on the bus cycle tag
  localparam int unsigned ERA_W = 4;

  // Sequential fetch step in bytes
  localparam int unsigned INST_BYTES = 4;

  // FIFO fill count, good for up to 15 entries
  localparam int unsigned FIFO_CNT_W = 4;

endpackage

`default_nettype wire
